//--- mini_core.f
+incdir+include
hdl/core_pkg.sv
hdl/frontend.sv
hdl/id_stage.sv
hdl/issue_stage.sv
hdl/ex_stage.sv
hdl/controller.sv
hdl/mini_core.sv
verification/mini_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the mini_core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module mini_core_tb \
  -f mini_core.f \
  -o sim_mini_core

./obj_dir/sim_mini_core | tee sim.log

if grep -q "Testbench failed" sim.log; then
  echo "Simulation reported errors, see sim.log"
  exit 1
fi

echo "Simulation finished, see sim.log"

//--- include/tb_ref_model.svh
// Reference model of the supported RV32I subset
// Executes one word and returns the expected trace record
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

function automatic core_pkg::commit_t ref_step(
  input logic [31:0] instr,
  inout logic [31:0] pc,
  inout logic [31:0] regs [32]
);
  core_pkg::commit_t rec;
  logic [31:0]       op_a;
  logic [31:0]       op_b;
  logic [31:0]       wdata;
  logic [31:0]       next_pc;
  logic              writes;
  logic              illegal;

  op_a    = regs[instr[19:15]];
  op_b    = regs[instr[24:20]];
  wdata   = '0;
  next_pc = pc + 32'd4;
  writes  = 1'b1;
  illegal = 1'b0;

  case (instr[6:0])
    7'b0010011: begin
      if (instr[14:12] == 3'b000) begin
        wdata = op_a + {{20{instr[31]}}, instr[31:20]};
      end else begin
        illegal = 1'b1;
      end
    end
    7'b0110011: begin
      case ({instr[31:25], instr[14:12]})
        10'b0000000_000: wdata = op_a + op_b;
        10'b0100000_000: wdata = op_a - op_b;
        10'b0000000_111: wdata = op_a & op_b;
        10'b0000000_110: wdata = op_a | op_b;
        10'b0000000_100: wdata = op_a ^ op_b;
        10'b0000000_010: wdata = {31'b0, $signed(op_a) < $signed(op_b)};
        default:         illegal = 1'b1;
      endcase
    end
    7'b0110111: wdata = {instr[31:12], 12'b0};
    7'b1100011: begin
      writes = 1'b0;
      if ((instr[14:12] == 3'b000 && op_a == op_b) ||
          (instr[14:12] == 3'b001 && op_a != op_b)) begin
        next_pc = pc + {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end else if (instr[14:13] != 2'b00) begin
        illegal = 1'b1;
      end
    end
    7'b1101111: begin
      wdata   = pc + 32'd4;
      next_pc = pc + {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    end
    default: illegal = 1'b1;
  endcase

  // Core stops on an illegal word
  if (illegal) begin
    writes  = 1'b0;
    wdata   = '0;
    next_pc = pc;
  end

  rec.valid   = 1'b1;
  rec.pc      = pc;
  rec.rd      = writes ? instr[11:7] : 5'd0;
  rec.wdata   = writes ? wdata : 32'd0;
  rec.illegal = illegal;

  if (writes && instr[11:7] != 5'd0) begin
    regs[instr[11:7]] = wdata;
  end
  pc = next_pc;
  return rec;
endfunction

`endif

//--- verification/mini_core_tb.sv
// Testbench for the mini RV32I core
// AXI4-Lite instruction memory, program load and commit trace comparison
`timescale 1ns/10ps
`default_nettype none

module mini_core_tb;

  localparam logic [31:0] BOOT_ADDR    = 32'h0000_0080;
  localparam int unsigned MEM_WORDS    = 256;
  localparam int unsigned MAX_STEPS    = 64;
  localparam int unsigned HALT_TIMEOUT = 4000;
  localparam int unsigned QUIET_CYCLES = 64;
  localparam int unsigned SEED         = 32'hd703_a42b;
  // Instruction fetch, unprivileged, secure
  localparam logic [2:0]  AR_PROT_EXP  = 3'b100;

  logic                       clk_i;
  logic                       rst_ni = 1'b0;
  core_pkg::axi_lite_ar_req_t axi_req;
  core_pkg::axi_lite_r_rsp_t  axi_rsp = '0;
  core_pkg::commit_t          commit;
  logic                       halted;

  logic [31:0]       mem [MEM_WORDS];
  logic [31:0]       next_addr;
  core_pkg::commit_t exp_q [$];
  int unsigned       exp_idx;
  logic              random_delays = 1'b0;
  logic              timed_out = 1'b0;
  int unsigned       seed_ret;

  // Memory model state
  logic              rd_pending;
  logic [31:0]       rd_addr;
  logic [3:0]        ar_wait;
  logic [3:0]        r_wait;
  logic              halt_idle;
  int unsigned       late_ar;

  int unsigned       commit_errors;
  int unsigned       halt_errors;
  int unsigned       prot_errors;
  int unsigned       extra_commits;
  int unsigned       other_errors;

  `include "tb_ref_model.svh"

  mini_core #(
    .BootAddr ( BOOT_ADDR )
  ) dut0 (
    .clk_i     ( clk_i   ),
    .rst_ni    ( rst_ni  ),
    .axi_req_o ( axi_req ),
    .axi_rsp_i ( axi_rsp ),
    .commit_o  ( commit  ),
    .halted_o  ( halted  )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // Instruction encoders
  // ----------------------------------------
  function automatic logic [31:0] addi_word(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] rtype_word(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                             logic [4:0] rs1, logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] lui_word(logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] branch_word(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                              logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal_word(logic [4:0] rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  task automatic place_word(input logic [31:0] w);
    mem[next_addr[9:2]] = w;
    next_addr += 32'd4;
  endtask

  task automatic load_program();
    // Unused words decode as illegal, each one tagged with its own address
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i[7:0]] = {i[24:0], 7'h7f};
    end
    next_addr = BOOT_ADDR;
    // Straight-line arithmetic
    place_word(addi_word(5'd1, 5'd0, 12'd5));
    place_word(addi_word(5'd2, 5'd0, 12'hffd));
    place_word(rtype_word(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
    place_word(rtype_word(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));
    place_word(rtype_word(7'h00, 3'b111, 5'd5, 5'd1, 5'd2));
    place_word(rtype_word(7'h00, 3'b110, 5'd6, 5'd1, 5'd2));
    place_word(rtype_word(7'h00, 3'b100, 5'd7, 5'd1, 5'd2));
    place_word(rtype_word(7'h00, 3'b010, 5'd8, 5'd2, 5'd1));
    place_word(lui_word(5'd9, 20'h12345));
    // Back-to-back dependent chain
    place_word(addi_word(5'd10, 5'd0, 12'd1));
    place_word(rtype_word(7'h00, 3'b000, 5'd10, 5'd10, 5'd10));
    place_word(rtype_word(7'h00, 3'b000, 5'd10, 5'd10, 5'd10));
    place_word(rtype_word(7'h20, 3'b000, 5'd11, 5'd10, 5'd1));
    place_word(rtype_word(7'h00, 3'b010, 5'd12, 5'd11, 5'd0));
    place_word(rtype_word(7'h00, 3'b100, 5'd13, 5'd12, 5'd11));
    place_word(addi_word(5'd13, 5'd13, 12'd7));
    // Taken and not-taken control flow
    place_word(branch_word(3'b000, 5'd1, 5'd1, 13'd12));
    place_word(addi_word(5'd20, 5'd0, 12'd1));
    place_word(addi_word(5'd20, 5'd0, 12'd2));
    place_word(branch_word(3'b001, 5'd1, 5'd2, 13'd8));
    place_word(addi_word(5'd21, 5'd0, 12'd3));
    place_word(branch_word(3'b000, 5'd1, 5'd2, 13'd8));
    place_word(addi_word(5'd21, 5'd0, 12'd4));
    place_word(branch_word(3'b001, 5'd1, 5'd1, 13'd8));
    place_word(jal_word(5'd22, 21'd12));
    place_word(addi_word(5'd23, 5'd0, 12'd5));
    place_word(addi_word(5'd23, 5'd0, 12'd6));
    place_word(rtype_word(7'h00, 3'b000, 5'd24, 5'd22, 5'd0));
    place_word(addi_word(5'd25, 5'd24, 12'd1));
    // Stop word
    place_word(32'h0000_0000);
  endtask

  task automatic build_expected();
    logic [31:0]       regs [32];
    logic [31:0]       pc;
    core_pkg::commit_t rec;
    for (int i = 0; i < 32; i++) begin
      regs[i[4:0]] = '0;
    end
    pc = BOOT_ADDR;
    for (int n = 0; n < MAX_STEPS; n++) begin
      rec = ref_step(mem[pc[9:2]], pc, regs);
      exp_q.push_back(rec);
      if (rec.illegal) begin
        break;
      end
    end
  endtask

  function automatic logic [3:0] pick_delay();
    if (random_delays) begin
      return 4'($urandom_range(4, 0));
    end
    return 4'd0;
  endfunction

  // ----------------------------------------
  // AXI4-Lite instruction memory
  // ----------------------------------------
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      axi_rsp    <= '0;
      rd_pending <= 1'b0;
      rd_addr    <= '0;
      ar_wait    <= '0;
      r_wait     <= '0;
      halt_idle  <= 1'b0;
      late_ar    <= 0;
    end else begin
      // A request still pending at the halt must complete, later ones may not start
      if (halted && !axi_req.ar_valid) begin
        halt_idle <= 1'b1;
      end
      if (axi_req.ar_valid && axi_rsp.ar_ready) begin
        axi_rsp.ar_ready <= 1'b0;
        rd_pending       <= 1'b1;
        rd_addr          <= axi_req.ar_addr;
        r_wait           <= pick_delay();
        check_prot(axi_req);
        if (halt_idle) begin
          late_ar <= late_ar + 1;
        end
      end else if (axi_req.ar_valid && !rd_pending) begin
        if (ar_wait == 4'd0) begin
          axi_rsp.ar_ready <= 1'b1;
        end else begin
          ar_wait <= ar_wait - 4'd1;
        end
      end
      if (rd_pending && !axi_rsp.r_valid) begin
        if (r_wait == 4'd0) begin
          axi_rsp.r_valid <= 1'b1;
          axi_rsp.r_data  <= mem[rd_addr[9:2]];
          axi_rsp.r_resp  <= core_pkg::AXI_RESP_OKAY;
        end else begin
          r_wait <= r_wait - 4'd1;
        end
      end
      if (axi_rsp.r_valid && axi_req.r_ready) begin
        axi_rsp.r_valid <= 1'b0;
        rd_pending      <= 1'b0;
        ar_wait         <= pick_delay();
      end
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  task automatic check_commit(input core_pkg::commit_t got, input core_pkg::commit_t want);
    if (got !== want) begin
      commit_errors++;
      $display("Fail commit_o: pc %h rd %h wdata %h ill %h, exp pc %h rd %h wdata %h ill %h",
               got.pc, got.rd, got.wdata, got.illegal,
               want.pc, want.rd, want.wdata, want.illegal);
    end
  endtask

  task automatic check_halt(input logic want);
    if (halted !== want) begin
      halt_errors++;
      $display("Fail halted_o: got %h expected %h", halted, want);
    end
  endtask

  task automatic check_prot(input core_pkg::axi_lite_ar_req_t req);
    if (req.ar_prot !== AR_PROT_EXP) begin
      prot_errors++;
      $display("Fail ar_prot: got %h expected %h", req.ar_prot, AR_PROT_EXP);
    end
  endtask

  // Walks the expected trace one commit beat at a time
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      exp_idx = 0;
    end else if (commit.valid) begin
      if (exp_idx < exp_q.size()) begin
        check_commit(commit, exp_q[exp_idx]);
        exp_idx++;
      end else begin
        extra_commits++;
        $display("Unexpected commit at pc %h after the expected trace ended", commit.pc);
      end
    end
  end

  task automatic run_pass(input logic use_delays);
    int unsigned cycles;
    @(posedge clk_i);
    rst_ni        <= 1'b0;
    random_delays <= use_delays;
    repeat (16) @(posedge clk_i);
    check_halt(1'b0);
    if (axi_req.ar_valid || commit.valid) begin
      other_errors++;
      $display("Read request or commit seen while reset was held");
    end
    rst_ni <= 1'b1;
    cycles = 0;
    while (!halted && cycles < HALT_TIMEOUT) begin
      @(posedge clk_i);
      cycles++;
    end
    if (!halted) begin
      other_errors++;
      timed_out = 1'b1;
      $display("Timeout: core did not halt within %0d cycles", HALT_TIMEOUT);
    end else begin
      // Quiet window after the halt
      repeat (QUIET_CYCLES) @(posedge clk_i);
      check_halt(1'b1);
      if (exp_idx != exp_q.size()) begin
        other_errors++;
        $display("Only %0d of %0d expected commits were seen", exp_idx, exp_q.size());
      end
      if (late_ar != 0) begin
        other_errors++;
        $display("%0d read requests were accepted after the core halted", late_ar);
      end
    end
  endtask

  initial begin
    seed_ret      = $urandom(SEED);
    commit_errors = 0;
    halt_errors   = 0;
    prot_errors   = 0;
    extra_commits = 0;
    other_errors  = 0;
    load_program();
    build_expected();
    // First pass with an always-ready memory, second with random delays
    for (int pass = 0; pass < 2; pass++) begin
      if (!timed_out) begin
        run_pass(pass == 1);
      end
    end
    $display("Errors: commit %0d, halt %0d, prot %0d, extra commits %0d, other %0d",
             commit_errors, halt_errors, prot_errors, extra_commits, other_errors);
    if (commit_errors + halt_errors + prot_errors + extra_commits + other_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/mini_core.sv
// Mini RV32I core
// Fetch, decode, issue, execute and control wired into one in-order pipeline
`timescale 1ns/10ps
`default_nettype none

module mini_core #(
  parameter logic [core_pkg::XLEN-1:0] BootAddr = '0
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  output core_pkg::axi_lite_ar_req_t axi_req_o,
  input  core_pkg::axi_lite_r_rsp_t  axi_rsp_i,
  output core_pkg::commit_t          commit_o,
  output logic                       halted_o
);

  // ----------------------------------------
  // Stage connections
  // ----------------------------------------
  core_pkg::fetch_entry_t fetch_entry_if_id;
  logic                   fetch_valid_if_id;
  logic                   fetch_ready_id_if;

  core_pkg::decoded_t     decoded_id_issue;
  logic                   decoded_valid_id_issue;
  logic                   decoded_ready_issue_id;

  core_pkg::issue_t       issue_issue_ex;
  logic                   issue_valid_issue_ex;

  core_pkg::redirect_t    redirect_ex_ctrl;
  core_pkg::redirect_t    redirect_ctrl_if;
  logic                   flush_ctrl;

  frontend #(
    .BootAddr ( BootAddr )
  ) frontend_i (
    .clk_i         ( clk_i             ),
    .rst_ni        ( rst_ni            ),
    .redirect_i    ( redirect_ctrl_if  ),
    .halt_i        ( halted_o          ),
    .axi_req_o     ( axi_req_o         ),
    .axi_rsp_i     ( axi_rsp_i         ),
    .fetch_entry_o ( fetch_entry_if_id ),
    .fetch_valid_o ( fetch_valid_if_id ),
    .fetch_ready_i ( fetch_ready_id_if )
  );

  id_stage id_stage_i (
    .clk_i           ( clk_i                  ),
    .rst_ni          ( rst_ni                 ),
    .flush_i         ( flush_ctrl             ),
    .fetch_entry_i   ( fetch_entry_if_id      ),
    .fetch_valid_i   ( fetch_valid_if_id      ),
    .fetch_ready_o   ( fetch_ready_id_if      ),
    .decoded_o       ( decoded_id_issue       ),
    .decoded_valid_o ( decoded_valid_id_issue ),
    .decoded_ready_i ( decoded_ready_issue_id )
  );

  issue_stage issue_stage_i (
    .clk_i           ( clk_i                  ),
    .rst_ni          ( rst_ni                 ),
    .flush_i         ( flush_ctrl             ),
    .decoded_i       ( decoded_id_issue       ),
    .decoded_valid_i ( decoded_valid_id_issue ),
    .decoded_ready_o ( decoded_ready_issue_id ),
    .commit_i        ( commit_o               ),
    .issue_o         ( issue_issue_ex         ),
    .issue_valid_o   ( issue_valid_issue_ex   )
  );

  ex_stage ex_stage_i (
    .clk_i         ( clk_i                ),
    .rst_ni        ( rst_ni               ),
    .flush_i       ( flush_ctrl           ),
    .issue_i       ( issue_issue_ex       ),
    .issue_valid_i ( issue_valid_issue_ex ),
    .commit_o      ( commit_o             ),
    .redirect_o    ( redirect_ex_ctrl     )
  );

  controller controller_i (
    .clk_i      ( clk_i            ),
    .rst_ni     ( rst_ni           ),
    .commit_i   ( commit_o         ),
    .redirect_i ( redirect_ex_ctrl ),
    .redirect_o ( redirect_ctrl_if ),
    .flush_o    ( flush_ctrl       ),
    .halt_o     ( halted_o         )
  );

endmodule

`default_nettype wire

//--- hdl/controller.sv
// Controller
// Run/halt state and pipeline flush from redirects and illegal commits
`timescale 1ns/10ps
`default_nettype none

module controller (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  core_pkg::commit_t   commit_i,
  input  core_pkg::redirect_t redirect_i,
  output core_pkg::redirect_t redirect_o,
  output logic                flush_o,
  output logic                halt_o
);

  typedef enum logic {
    CTRL_RUN,
    CTRL_HALTED
  } ctrl_state_e;

  ctrl_state_e state_q;
  logic        illegal_commit;

  assign illegal_commit = commit_i.valid && commit_i.illegal;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CTRL_RUN;
    end else if (illegal_commit) begin
      state_q <= CTRL_HALTED;
    end
  end

  // Halted core ignores any further redirect
  assign redirect_o.valid = redirect_i.valid && (state_q == CTRL_RUN);
  assign redirect_o.pc    = redirect_i.pc;

  assign halt_o  = (state_q == CTRL_HALTED) || illegal_commit;
  assign flush_o = redirect_o.valid || halt_o;

endmodule

`default_nettype wire

//--- hdl/ex_stage.sv
// Execute stage
// ALU, branch resolution and the registered commit record and redirect
`timescale 1ns/10ps
`default_nettype none

module ex_stage (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  input  core_pkg::issue_t    issue_i,
  input  logic                issue_valid_i,
  output core_pkg::commit_t   commit_o,
  output core_pkg::redirect_t redirect_o
);

  core_pkg::decoded_t        dec;
  logic [core_pkg::XLEN-1:0] op_a;
  logic [core_pkg::XLEN-1:0] op_b;
  logic [core_pkg::XLEN-1:0] result;
  logic                      taken;
  logic                      writes;
  core_pkg::commit_t         commit_d, commit_q;
  core_pkg::redirect_t       redirect_d, redirect_q;

  assign dec  = issue_i.dec;
  assign op_a = issue_i.rs1_val;
  assign op_b = issue_i.rs2_val;

  always_comb begin
    result = '0;
    taken  = 1'b0;
    writes = 1'b1;
    unique case (dec.op)
      core_pkg::OP_ADDI: result = op_a + dec.imm;
      core_pkg::OP_ADD:  result = op_a + op_b;
      core_pkg::OP_SUB:  result = op_a - op_b;
      core_pkg::OP_AND:  result = op_a & op_b;
      core_pkg::OP_OR:   result = op_a | op_b;
      core_pkg::OP_XOR:  result = op_a ^ op_b;
      core_pkg::OP_SLT:  result = {{(core_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      core_pkg::OP_LUI:  result = dec.imm;
      core_pkg::OP_JAL: begin
        // Link address
        result = dec.pc + 32'd4;
        taken  = 1'b1;
      end
      core_pkg::OP_BEQ: begin
        writes = 1'b0;
        taken  = (op_a == op_b);
      end
      core_pkg::OP_BNE: begin
        writes = 1'b0;
        taken  = (op_a != op_b);
      end
      default: writes = 1'b0;
    endcase
  end

  // Branches and illegal words report rd 0 and no data
  assign commit_d.valid   = issue_valid_i;
  assign commit_d.pc      = dec.pc;
  assign commit_d.rd      = writes ? dec.rd : '0;
  assign commit_d.wdata   = result;
  assign commit_d.illegal = dec.illegal;

  assign redirect_d.valid = issue_valid_i && taken;
  assign redirect_d.pc    = dec.pc + dec.imm;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      commit_q   <= '0;
      redirect_q <= '0;
    end else begin
      commit_q   <= commit_d;
      redirect_q <= redirect_d;
      if (flush_i) begin
        commit_q.valid   <= 1'b0;
        redirect_q.valid <= 1'b0;
      end
    end
  end

  assign commit_o   = commit_q;
  assign redirect_o = redirect_q;

endmodule

`default_nettype wire

//--- hdl/issue_stage.sv
// Issue stage
// Register file with operand read, forwarding from commit, and issue to EX
`timescale 1ns/10ps
`default_nettype none

module issue_stage (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               flush_i,
  input  core_pkg::decoded_t decoded_i,
  input  logic               decoded_valid_i,
  output logic               decoded_ready_o,
  input  core_pkg::commit_t  commit_i,
  output core_pkg::issue_t   issue_o,
  output logic               issue_valid_o
);

  logic [core_pkg::XLEN-1:0]       regs_q [1:31];
  logic                            wen;
  logic [core_pkg::REG_ADDR_W-1:0] rs_idx [2];
  logic [core_pkg::XLEN-1:0]       rs_val [2];

  // Retired result lands in the register file at the end of the commit cycle
  assign wen = commit_i.valid && !commit_i.illegal && (commit_i.rd != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wen) begin
      regs_q[commit_i.rd] <= commit_i.wdata;
    end
  end

  // ----------------------------------------
  // Operand read
  // ----------------------------------------
  assign rs_idx[0] = decoded_i.rs1;
  assign rs_idx[1] = decoded_i.rs2;

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      if (rs_idx[i] == '0) begin
        rs_val[i] = '0;
      end else if (wen && (commit_i.rd == rs_idx[i])) begin
        // Producer sits in the commit register
        rs_val[i] = commit_i.wdata;
      end else begin
        rs_val[i] = regs_q[rs_idx[i]];
      end
    end
  end

  // EX never stalls, only a flush holds issue back
  assign decoded_ready_o = !flush_i;
  assign issue_valid_o   = decoded_valid_i && !flush_i;

  assign issue_o.dec     = decoded_i;
  assign issue_o.rs1_val = rs_val[0];
  assign issue_o.rs2_val = rs_val[1];

endmodule

`default_nettype wire

//--- hdl/id_stage.sv
// Decode stage
// Turns a fetched word into a decoded record held in a one-entry register
`timescale 1ns/10ps
`default_nettype none

module id_stage (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  core_pkg::fetch_entry_t fetch_entry_i,
  input  logic                   fetch_valid_i,
  output logic                   fetch_ready_o,
  output core_pkg::decoded_t     decoded_o,
  output logic                   decoded_valid_o,
  input  logic                   decoded_ready_i
);

  logic [31:0]        instr;
  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  logic               accept;
  core_pkg::decoded_t dec_d, dec_q;
  logic               valid_q;

  assign instr  = fetch_entry_i.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  always_comb begin
    dec_d.pc  = fetch_entry_i.pc;
    dec_d.op  = core_pkg::OP_ILLEGAL;
    dec_d.rd  = instr[11:7];
    dec_d.rs1 = instr[19:15];
    dec_d.rs2 = instr[24:20];
    dec_d.imm = '0;

    case (opcode)
      7'b0010011: begin
        dec_d.imm = {{20{instr[31]}}, instr[31:20]};
        if (funct3 == 3'b000) begin
          dec_d.op = core_pkg::OP_ADDI;
        end
      end
      7'b0110011: begin
        case ({funct7, funct3})
          10'b0000000_000: dec_d.op = core_pkg::OP_ADD;
          10'b0100000_000: dec_d.op = core_pkg::OP_SUB;
          10'b0000000_111: dec_d.op = core_pkg::OP_AND;
          10'b0000000_110: dec_d.op = core_pkg::OP_OR;
          10'b0000000_100: dec_d.op = core_pkg::OP_XOR;
          10'b0000000_010: dec_d.op = core_pkg::OP_SLT;
          default:         dec_d.op = core_pkg::OP_ILLEGAL;
        endcase
      end
      7'b0110111: begin
        dec_d.op  = core_pkg::OP_LUI;
        dec_d.imm = {instr[31:12], 12'b0};
      end
      7'b1100011: begin
        // B-type offset
        dec_d.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        if (funct3 == 3'b000) begin
          dec_d.op = core_pkg::OP_BEQ;
        end else if (funct3 == 3'b001) begin
          dec_d.op = core_pkg::OP_BNE;
        end
      end
      7'b1101111: begin
        // J-type offset
        dec_d.op  = core_pkg::OP_JAL;
        dec_d.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: dec_d.op = core_pkg::OP_ILLEGAL;
    endcase

    dec_d.illegal = (dec_d.op == core_pkg::OP_ILLEGAL);
  end

  // One-entry buffer, refilled in the cycle it drains
  assign fetch_ready_o = !valid_q || decoded_ready_i;
  assign accept        = fetch_valid_i && fetch_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      dec_q   <= '0;
    end else begin
      if (accept) begin
        valid_q <= 1'b1;
        dec_q   <= dec_d;
      end else if (decoded_ready_i) begin
        valid_q <= 1'b0;
      end
      if (flush_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  assign decoded_o       = dec_q;
  assign decoded_valid_o = valid_q;

endmodule

`default_nettype wire

//--- hdl/frontend.sv
// Instruction fetch
// Generates the PC and reads one word at a time over AXI4-Lite
`timescale 1ns/10ps
`default_nettype none

module frontend #(
  parameter logic [core_pkg::XLEN-1:0] BootAddr = '0
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  core_pkg::redirect_t        redirect_i,
  input  logic                       halt_i,
  output core_pkg::axi_lite_ar_req_t axi_req_o,
  input  core_pkg::axi_lite_r_rsp_t  axi_rsp_i,
  output core_pkg::fetch_entry_t     fetch_entry_o,
  output logic                       fetch_valid_o,
  input  logic                       fetch_ready_i
);

  typedef enum logic [1:0] {
    FE_IDLE,
    FE_AR,
    FE_R,
    FE_HOLD
  } fe_state_e;

  fe_state_e                 state_q, state_d;
  logic [core_pkg::XLEN-1:0] pc_q, pc_d;
  logic [core_pkg::XLEN-1:0] addr_q;
  logic [31:0]               instr_q;
  logic                      discard_q, discard_d;
  logic                      ar_hs;
  logic                      r_hs;
  logic                      resp_ok;

  // Address stays stable in FE_AR, so it comes from addr_q
  assign axi_req_o.ar_valid = (state_q == FE_AR);
  assign axi_req_o.ar_addr  = addr_q;
  assign axi_req_o.ar_prot  = core_pkg::AXI_PROT_INSTR;
  assign axi_req_o.r_ready  = (state_q == FE_R);

  assign ar_hs   = axi_req_o.ar_valid && axi_rsp_i.ar_ready;
  assign r_hs    = axi_req_o.r_ready && axi_rsp_i.r_valid;
  assign resp_ok = (axi_rsp_i.r_resp == core_pkg::AXI_RESP_OKAY);

  assign fetch_entry_o.pc    = addr_q;
  assign fetch_entry_o.instr = instr_q;
  assign fetch_valid_o       = (state_q == FE_HOLD);

  always_comb begin
    state_d   = state_q;
    pc_d      = pc_q;
    discard_d = discard_q;

    unique case (state_q)
      FE_IDLE: begin
        if (!halt_i && !redirect_i.valid) begin
          state_d = FE_AR;
        end
      end
      FE_AR: begin
        if (ar_hs) begin
          state_d = FE_R;
        end
      end
      FE_R: begin
        if (r_hs) begin
          discard_d = 1'b0;
          // Stale, killed or failed reads go back to idle and refetch
          if (discard_q || halt_i || redirect_i.valid || !resp_ok) begin
            state_d = FE_IDLE;
          end else begin
            state_d = FE_HOLD;
          end
        end
      end
      FE_HOLD: begin
        if (fetch_ready_i || redirect_i.valid || halt_i) begin
          state_d = FE_IDLE;
        end
      end
      default: state_d = FE_IDLE;
    endcase

    // Sequential fetch
    if (fetch_valid_o && fetch_ready_i) begin
      pc_d = pc_q + 32'd4;
    end

    if (redirect_i.valid) begin
      pc_d = redirect_i.pc;
      // Read still in flight returns a word from the old path
      if ((state_q == FE_AR) || ((state_q == FE_R) && !r_hs)) begin
        discard_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= FE_IDLE;
      pc_q      <= BootAddr;
      discard_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      pc_q      <= pc_d;
      discard_q <= discard_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == FE_IDLE) begin
      addr_q <= pc_q;
    end
    if (r_hs) begin
      instr_q <= axi_rsp_i.r_data;
    end
  end

endmodule

`default_nettype wire

//--- hdl/core_pkg.sv
// Core package
// Widths, opcodes and the records passed between the pipeline stages
`default_nettype none

package core_pkg;

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;

  // AXI4-Lite response code and fetch protection (instruction, unprivileged)
  localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;
  localparam logic [2:0] AXI_PROT_INSTR = 3'b100;

  typedef enum logic [3:0] {
    OP_ADDI,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLT,
    OP_LUI,
    OP_BEQ,
    OP_BNE,
    OP_JAL,
    OP_ILLEGAL
  } op_e;

  // ----------------------------------------
  // Pipeline records
  // ----------------------------------------
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [31:0]     instr;
  } fetch_entry_t;

  typedef struct packed {
    logic [XLEN-1:0]       pc;
    op_e                   op;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       imm;
    logic                  illegal;
  } decoded_t;

  typedef struct packed {
    decoded_t        dec;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
  } issue_t;

  // One retired instruction on the trace port
  typedef struct packed {
    logic                  valid;
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       wdata;
    logic                  illegal;
  } commit_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
  } redirect_t;

  // ----------------------------------------
  // AXI4-Lite read channels
  // ----------------------------------------
  typedef struct packed {
    logic            ar_valid;
    logic [XLEN-1:0] ar_addr;
    logic [2:0]      ar_prot;
    logic            r_ready;
  } axi_lite_ar_req_t;

  typedef struct packed {
    logic            ar_ready;
    logic            r_valid;
    logic [XLEN-1:0] r_data;
    logic [1:0]      r_resp;
  } axi_lite_r_rsp_t;

endpackage

`default_nettype wire
